/* sim.f */
common/array_pkg.sv
design/cpu_bus_decoder.sv
normal/normal_ram.sv
normal/normal_operator.sv
pwm/pwm_timer.sv
pwm/pwm_generator.sv
design/array_top.sv
testbench/tb_clock.sv
testbench/array_tb.sv

/* testbench/array_tb.sv */
// Phased array controller testbench
module array_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N       = array_pkg::NUM_TRANS;
    localparam int BASE    = int'(array_pkg::ADDR_NORMAL_BASE);
    localparam int CTRL    = int'(array_pkg::ADDR_CTRL);
    localparam int CYCLE   = int'(array_pkg::ADDR_CYCLE);
    localparam int SYNC_TO = 1000;  // Clocks allowed while waiting for period_sync

    logic                         CLK;
    logic                         RST;
    logic                         bus_en;
    logic                         bus_we;
    logic [array_pkg::ADDR_W-1:0] bus_addr;
    logic [array_pkg::DATA_W-1:0] bus_wdata;
    logic [array_pkg::DATA_W-1:0] bus_rdata;
    logic [N-1:0]                 pwm_out;
    logic                         period_sync;

    // Model of the memory words and both registers
    logic [15:0] mem_model [2*N];
    logic [1:0]  ctrl_model;
    int          cycle_model;
    int          seed = 32'he0bbfeb0;
    int          checks;
    int          errors;
    int          timeouts;

    tb_clock u_clock (.CLK(CLK), .RST(RST));

    array_top u_array_top (
        .CLK         (CLK),
        .RST         (RST),
        .bus_en      (bus_en),
        .bus_we      (bus_we),
        .bus_addr    (bus_addr),
        .bus_wdata   (bus_wdata),
        .bus_rdata   (bus_rdata),
        .pwm_out     (pwm_out),
        .period_sync (period_sync)
    );

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // Pin predictor for count t
    function automatic logic [N-1:0] expected_pins(input int t);
        logic [N-1:0] pins;
        int ph;
        int du;
        int off;
        for (int i = 0; i < N; i++) begin
            if (ctrl_model != 2'd0) begin
                ph = int'(mem_model[2*i][7:0]) * 32;       // Legacy bytes
                du = int'(mem_model[2*i][15:8]) * 8 + 8;
            end else begin
                ph = int'(mem_model[2*i][12:0]);
                du = int'(mem_model[2*i+1][12:0]);
            end
            off = ((t - ph) % cycle_model + cycle_model) % cycle_model;
            pins[i] = off < du;
        end
        return pins;
    endfunction

    // Called just after a falling edge, so calls in a row are back to back
    task automatic bus_write(input int addr, input int data);
        bus_en    = 1'b1;
        bus_we    = 1'b1;
        bus_addr  = addr[array_pkg::ADDR_W-1:0];
        bus_wdata = data[15:0];
        @(negedge CLK);
        bus_en = 1'b0;
        bus_we = 1'b0;
        if (addr == CTRL) ctrl_model = data[1:0];
        if (addr == CYCLE) cycle_model = data % 8192;
        if (addr >= BASE && addr < BASE + 2*N) mem_model[addr-BASE] = data[15:0];
    endtask

    task automatic check_read(input int addr, input int expected);
        bus_en   = 1'b1;
        bus_we   = 1'b0;
        bus_addr = addr[array_pkg::ADDR_W-1:0];
        @(negedge CLK);
        bus_en = 1'b0;
        checks++;
        assert (bus_rdata === expected[15:0])
        else begin
            errors++;
            $display("** Error: bus_rdata at %h got %h expected %h",
                     addr[9:0], bus_rdata, expected[15:0]);
        end
    endtask

    task automatic wait_sync();
        int n;
        n = 0;
        while (!period_sync && n < SYNC_TO && timeouts == 0) begin
            @(negedge CLK);
            n++;
        end
        if (!period_sync && timeouts == 0) begin
            timeouts++;
            $display("period_sync did not arrive within %0d clocks", SYNC_TO);
        end
    endtask

    // Frame swap latency plus two periods
    task automatic settle();
        repeat (48) @(negedge CLK);
        wait_sync();
        @(negedge CLK);
        wait_sync();
        @(negedge CLK);
    endtask

    // Compares one full period, count 0 at the period_sync cycle
    task automatic check_period();
        logic [N-1:0] exp_pins;
        wait_sync();
        if (timeouts == 0) begin
            for (int t = 0; t < cycle_model; t++) begin
                exp_pins = expected_pins(t);
                checks++;
                assert (pwm_out === exp_pins)
                else begin
                    errors++;
                    $display("** Error: pwm_out at count %0d got %h expected %h",
                             t, pwm_out, exp_pins);
                end
                assert (period_sync === (t == 0))
                else begin
                    errors++;
                    $display("** Error: period_sync at count %0d got %h expected %h",
                             t, period_sync, t == 0);
                end
                @(negedge CLK);
            end
            checks++;
            assert (period_sync === 1'b1)  // Spacing of exactly one cycle
            else begin
                errors++;
                $display("** Error: period_sync after %0d clocks got %h expected 1",
                         cycle_model, period_sync);
            end
        end
    endtask

    task automatic write_full_frame();
        int du;
        for (int i = 0; i < N; i++) begin
            case (rand_range(0, 3))
                0:       du = 0;
                1:       du = cycle_model + rand_range(0, 100);  // Constant high
                default: du = rand_range(1, cycle_model - 1);
            endcase
            bus_write(BASE + 2*i, (rand_range(0, 7) << 13) + rand_range(0, cycle_model - 1));
            bus_write(BASE + 2*i + 1, du);
        end
    endtask

    task automatic write_legacy_frame();
        for (int i = 0; i < N; i++) begin
            bus_write(BASE + 2*i, (rand_range(0, 255) << 8) +
                      rand_range(0, (cycle_model - 1) / 32));
            bus_write(BASE + 2*i + 1, rand_range(0, 65535));
        end
    endtask

    initial begin
        int n;
        int max_ph;
        bus_en      = 1'b0;
        bus_we      = 1'b0;
        bus_addr    = '0;
        bus_wdata   = '0;
        checks      = 0;
        errors      = 0;
        timeouts    = 0;
        ctrl_model  = 2'd0;
        cycle_model = int'(array_pkg::CYCLE_RESET);
        foreach (mem_model[i]) mem_model[i] = '0;

        // Outputs while reset is still held
        repeat (2) @(negedge CLK);
        checks++;
        assert (pwm_out === '0 && period_sync === 1'b0)
        else begin
            errors++;
            $display("** Error: pwm_out %h period_sync %h in reset expected 0",
                     pwm_out, period_sync);
        end
        n = 0;
        while (RST && n < 20) begin
            @(negedge CLK);
            n++;
        end
        if (RST) begin
            timeouts++;
            $display("Reset was never released");
        end
        check_read(CTRL, 0);
        check_read(CYCLE, cycle_model);

        repeat (4) begin
            n = rand_range(0, 65535);
            bus_write(CTRL, n);
            check_read(CTRL, n % 4);
            n = rand_range(0, 65535);
            bus_write(CYCLE, n);
            check_read(CYCLE, n % 8192);
            check_read(rand_range(2, 255), 0);
            check_read(rand_range(BASE + 2*N, 1023), 0);
        end

        // Full format
        bus_write(CTRL, 0);
        bus_write(CYCLE, rand_range(40, 300));
        write_full_frame();
        settle();
        repeat (2) check_period();

        // Legacy format, then odd words changed alone
        bus_write(CTRL, rand_range(1, 3));
        write_legacy_frame();
        settle();
        repeat (2) check_period();
        for (int i = 0; i < N; i++) bus_write(BASE + 2*i + 1, rand_range(0, 65535));
        settle();
        check_period();

        // New cycles above every scaled phase
        repeat (3) begin
            max_ph = 0;
            for (int i = 0; i < N; i++) begin
                if (int'(mem_model[2*i][7:0]) * 32 > max_ph) max_ph = mem_model[2*i][7:0] * 32;
            end
            bus_write(CYCLE, rand_range((max_ph < 40) ? 40 : max_ph + 1, 300));
            settle();
            repeat (2) check_period();
        end

        // Whole frame rewritten back to back
        repeat (2) begin
            bus_write(CTRL, 0);
            bus_write(CYCLE, rand_range(40, 300));
            write_full_frame();
            settle();
            repeat (3) check_period();
        end

        $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* testbench/tb_clock.sv */
// Testbench clock and reset
module tb_clock (
    output logic CLK,
    output logic RST
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;  // 40 ns period
    end

    initial begin
        RST = 1'b1;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b0;
    end

endmodule

/* design/array_top.sv */
// Phased array controller top
module array_top (
    input  logic                            CLK,
    input  logic                            RST,
    input  logic                            bus_en,
    input  logic                            bus_we,
    input  logic [array_pkg::ADDR_W-1:0]    bus_addr,
    input  logic [array_pkg::DATA_W-1:0]    bus_wdata,
    output logic [array_pkg::DATA_W-1:0]    bus_rdata,
    output logic [array_pkg::NUM_TRANS-1:0] pwm_out,
    output logic                            period_sync
);

    logic                           ram_we;
    logic [array_pkg::SCAN_W:0]     ram_addr;
    logic [array_pkg::DATA_W-1:0]   ram_wdata;
    logic [array_pkg::SCAN_W-1:0]   ram_raddr;
    logic [2*array_pkg::DATA_W-1:0] ram_rdata;
    logic [1:0]                     legacy_mode;
    logic [array_pkg::WIDTH-1:0]    cycle;
    logic [array_pkg::WIDTH-1:0]    duty  [array_pkg::NUM_TRANS];
    logic [array_pkg::WIDTH-1:0]    phase [array_pkg::NUM_TRANS];
    logic [array_pkg::WIDTH-1:0]    period_count;
    logic                           period_start;

    cpu_bus_decoder u_decoder (
        .CLK         (CLK),
        .RST         (RST),
        .bus_en      (bus_en),
        .bus_we      (bus_we),
        .bus_addr    (bus_addr),
        .bus_wdata   (bus_wdata),
        .bus_rdata   (bus_rdata),
        .ram_we      (ram_we),
        .ram_addr    (ram_addr),
        .ram_wdata   (ram_wdata),
        .legacy_mode (legacy_mode),
        .cycle       (cycle)
    );

    // Host writes one side, the operator scans the other
    normal_ram u_normal_ram (
        .CLK   (CLK),
        .we    (ram_we),
        .waddr (ram_addr),
        .wdata (ram_wdata),
        .raddr (ram_raddr),
        .rdata (ram_rdata)
    );

    normal_operator u_normal_operator (
        .CLK         (CLK),
        .RST         (RST),
        .legacy_mode (legacy_mode),
        .ram_rdata   (ram_rdata),
        .ram_raddr   (ram_raddr),
        .duty        (duty),
        .phase       (phase)
    );

    pwm_timer u_timer (
        .CLK          (CLK),
        .RST          (RST),
        .cycle        (cycle),
        .period_count (period_count),
        .period_start (period_start)
    );

    pwm_generator u_generator (
        .CLK          (CLK),
        .RST          (RST),
        .period_count (period_count),
        .period_start (period_start),
        .cycle        (cycle),
        .duty         (duty),
        .phase        (phase),
        .pwm_out      (pwm_out),
        .period_sync  (period_sync)
    );

endmodule

/* pwm/pwm_generator.sv */
// Per-transducer pulse generators
module pwm_generator (
    input  logic                              CLK,
    input  logic                              RST,
    input  logic [array_pkg::WIDTH-1:0]       period_count,
    input  logic                              period_start,
    input  logic [array_pkg::WIDTH-1:0]       cycle,
    input  logic [array_pkg::WIDTH-1:0]       duty  [array_pkg::NUM_TRANS],
    input  logic [array_pkg::WIDTH-1:0]       phase [array_pkg::NUM_TRANS],
    output logic [array_pkg::NUM_TRANS-1:0]   pwm_out,
    output logic                              period_sync
);

    localparam int W = array_pkg::WIDTH;

    logic [W-1:0]                    duty_l  [array_pkg::NUM_TRANS];
    logic [W-1:0]                    phase_l [array_pkg::NUM_TRANS];
    logic [array_pkg::NUM_TRANS-1:0] pin_next;

    // Values held for the rest of the period
    always_ff @(posedge CLK) begin
        if (period_start) begin
            duty_l  <= duty;
            phase_l <= phase;
        end
    end

    for (genvar i = 0; i < array_pkg::NUM_TRANS; i++) begin : g_pin
        logic [W-1:0] d;
        logic [W-1:0] p;
        logic [W:0]   offs;

        // Count 0 already uses the newly latched values
        assign d = period_start ? duty[i] : duty_l[i];
        assign p = period_start ? phase[i] : phase_l[i];

        // (count - phase) mod cycle
        assign offs = (period_count >= p) ? {1'b0, period_count - p} :
                      {1'b0, period_count} + {1'b0, cycle} - {1'b0, p};

        assign pin_next[i] = offs < {1'b0, d};  // Duty >= cycle stays high
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            pwm_out     <= '0;
            period_sync <= 1'b0;
        end else begin
            pwm_out     <= pin_next;
            period_sync <= period_start;
        end
    end

endmodule

/* pwm/pwm_timer.sv */
// PWM period timer
module pwm_timer (
    input  logic                        CLK,
    input  logic                        RST,
    input  logic [array_pkg::WIDTH-1:0] cycle,
    output logic [array_pkg::WIDTH-1:0] period_count,
    output logic                        period_start
);

    logic [array_pkg::WIDTH:0] count_inc;
    logic                      wrap;

    assign count_inc = {1'b0, period_count} + 1'b1;
    assign wrap      = count_inc >= {1'b0, cycle};  // Also catches a shrunk cycle

    always_ff @(posedge CLK) begin
        if (RST) begin
            period_count <= '0;
            period_start <= 1'b1;  // Count 0 after reset starts a period
        end else begin
            period_count <= wrap ? '0 : count_inc[array_pkg::WIDTH-1:0];
            period_start <= wrap;
        end
    end

    a_count_in_range: assert property (@(posedge CLK) disable iff (RST)
        period_start && cycle > 1 |=> period_count < $past(cycle))
        else $error("period count escaped the cycle after a wrap");

endmodule

/* normal/normal_operator.sv */
// Normal mode frame operator
module normal_operator (
    input  logic                           CLK,
    input  logic                           RST,
    input  logic [1:0]                     legacy_mode,
    input  logic [2*array_pkg::DATA_W-1:0] ram_rdata,
    output logic [array_pkg::SCAN_W-1:0]   ram_raddr,
    output logic [array_pkg::WIDTH-1:0]    duty  [array_pkg::NUM_TRANS],
    output logic [array_pkg::WIDTH-1:0]    phase [array_pkg::NUM_TRANS]
);

    localparam int N = array_pkg::NUM_TRANS;
    localparam int W = array_pkg::WIDTH;

    logic [array_pkg::SCAN_W-1:0]   scan_idx;
    logic [array_pkg::SCAN_W-1:0]   set_idx;
    logic [2*array_pkg::DATA_W-1:0] word_q;
    logic [array_pkg::DATA_W-1:0]   phase_word;
    logic [array_pkg::DATA_W-1:0]   duty_word;
    logic [W-1:0]                   phase_conv;
    logic [W-1:0]                   duty_conv;

    // Shadow frame, filled one transducer per clock
    logic [W-1:0] phase_buf [N];
    logic [W-1:0] duty_buf  [N];

    assign ram_raddr = scan_idx;

    // Scan index and conversion index two behind it
    always_ff @(posedge CLK) begin
        if (RST) begin
            scan_idx <= '0;
            set_idx  <= array_pkg::SCAN_W'(N - 2);
        end else begin
            scan_idx <= (int'(scan_idx) == N - 1) ? '0 : scan_idx + 1'b1;
            set_idx  <= (int'(set_idx) == N - 1) ? '0 : set_idx + 1'b1;
        end
    end

    // Extra stage lines the memory word up with set_idx
    always_ff @(posedge CLK) begin
        word_q <= ram_rdata;
    end

    assign phase_word = word_q[array_pkg::DATA_W-1:0];
    assign duty_word  = word_q[2*array_pkg::DATA_W-1:array_pkg::DATA_W];

    always_comb begin
        if (legacy_mode != 2'd0) begin
            // Legacy bytes both sit in the phase word
            phase_conv = W'(phase_word[7:0]) << array_pkg::LEGACY_PHASE_SHIFT;
            duty_conv  = (W'(phase_word[15:8]) << array_pkg::LEGACY_DUTY_SHIFT) +
                         (W'(1) << array_pkg::LEGACY_DUTY_SHIFT);
        end else begin
            phase_conv = phase_word[W-1:0];
            duty_conv  = duty_word[W-1:0];
        end
    end

    always_ff @(posedge CLK) begin
        phase_buf[set_idx] <= phase_conv;
        duty_buf[set_idx]  <= duty_conv;
    end

    // Whole frame goes live at once, never half updated
    always_ff @(posedge CLK) begin
        if (RST) begin
            duty  <= '{default: '0};
            phase <= '{default: '0};
        end else if (set_idx == '0) begin
            duty  <= duty_buf;
            phase <= phase_buf;
        end
    end

    a_set_lags_scan: assert property (@(posedge CLK) disable iff (RST)
        int'(set_idx) == (int'(scan_idx) + N - 2) % N)
        else $error("conversion index out of step with scan index");

endmodule

/* normal/normal_ram.sv */
// Phase and duty memory
module normal_ram (
    input  logic                           CLK,
    input  logic                           we,
    input  logic [array_pkg::SCAN_W:0]     waddr,
    input  logic [array_pkg::DATA_W-1:0]   wdata,
    input  logic [array_pkg::SCAN_W-1:0]   raddr,
    output logic [2*array_pkg::DATA_W-1:0] rdata
);

    // Even words hold phase, odd words hold duty
    logic [array_pkg::DATA_W-1:0] phase_mem [array_pkg::NUM_TRANS];
    logic [array_pkg::DATA_W-1:0] duty_mem  [array_pkg::NUM_TRANS];

    always_ff @(posedge CLK) begin
        if (we && !waddr[0]) begin
            phase_mem[waddr[array_pkg::SCAN_W:1]] <= wdata;
        end
        if (we && waddr[0]) begin
            duty_mem[waddr[array_pkg::SCAN_W:1]] <= wdata;
        end
    end

    // Both words of one transducer in a single read
    always_ff @(posedge CLK) begin
        rdata <= {duty_mem[raddr], phase_mem[raddr]};
    end

endmodule

/* design/cpu_bus_decoder.sv */
// Host bus decoder
module cpu_bus_decoder (
    input  logic                           CLK,
    input  logic                           RST,
    input  logic                           bus_en,
    input  logic                           bus_we,
    input  logic [array_pkg::ADDR_W-1:0]   bus_addr,
    input  logic [array_pkg::DATA_W-1:0]   bus_wdata,
    output logic [array_pkg::DATA_W-1:0]   bus_rdata,
    output logic                           ram_we,
    output logic [array_pkg::SCAN_W:0]     ram_addr,
    output logic [array_pkg::DATA_W-1:0]   ram_wdata,
    output logic [1:0]                     legacy_mode,
    output logic [array_pkg::WIDTH-1:0]    cycle
);

    logic                         wr;
    logic                         rd;
    logic                         in_window;
    logic [array_pkg::ADDR_W-1:0] offset;

    assign wr = bus_en && bus_we;
    assign rd = bus_en && !bus_we;

    // Word offset into the phase and duty memory
    assign offset    = bus_addr - array_pkg::ADDR_NORMAL_BASE;
    assign in_window = (bus_addr >= array_pkg::ADDR_NORMAL_BASE) &&
                       (int'(offset) < array_pkg::NORMAL_WORDS);

    assign ram_we    = wr && in_window;
    assign ram_addr  = offset[array_pkg::SCAN_W:0];
    assign ram_wdata = bus_wdata;

    always_ff @(posedge CLK) begin
        if (RST) begin
            legacy_mode <= 2'd0;
            cycle       <= array_pkg::CYCLE_RESET;
        end else if (wr) begin
            if (bus_addr == array_pkg::ADDR_CTRL) begin
                legacy_mode <= bus_wdata[1:0];
            end
            if (bus_addr == array_pkg::ADDR_CYCLE) begin
                cycle <= bus_wdata[array_pkg::WIDTH-1:0];
            end
        end
    end

    // Readback one cycle after the request
    always_ff @(posedge CLK) begin
        if (RST) begin
            bus_rdata <= '0;
        end else if (rd) begin
            case (bus_addr)
                array_pkg::ADDR_CTRL:  bus_rdata <= array_pkg::DATA_W'(legacy_mode);
                array_pkg::ADDR_CYCLE: bus_rdata <= array_pkg::DATA_W'(cycle);
                default:               bus_rdata <= '0;  // Unmapped and memory window
            endcase
        end
    end

    // Memory window stays clear of the control registers
    a_ram_we_not_register: assert property (@(posedge CLK) disable iff (RST)
        ram_we |-> bus_addr != array_pkg::ADDR_CTRL && bus_addr != array_pkg::ADDR_CYCLE)
        else $error("memory write lands on a control register address");

endmodule

/* common/array_pkg.sv */
// Phased array shared definitions
package array_pkg;

    // Array geometry
    localparam int NUM_TRANS = 16;
    localparam int WIDTH     = 13;             // Phase, duty, cycle and timer values
    localparam int SCAN_W    = 4;              // Scan index over NUM_TRANS

    // Host bus
    localparam int ADDR_W = 10;
    localparam int DATA_W = 16;

    // Address map
    localparam logic [ADDR_W-1:0] ADDR_CTRL        = 10'h000;  // Bits 1:0 legacy mode
    localparam logic [ADDR_W-1:0] ADDR_CYCLE       = 10'h001;  // PWM period in clocks
    localparam logic [ADDR_W-1:0] ADDR_NORMAL_BASE = 10'h100;

    // Phase word then duty word for each transducer
    localparam int NORMAL_WORDS = 2 * NUM_TRANS;

    // Register reset values
    localparam logic [WIDTH-1:0] CYCLE_RESET = 13'd64;

    // Legacy 8-bit format scaling
    // Phase is the byte times 32, duty is the byte times 8 plus 8
    localparam int LEGACY_PHASE_SHIFT = 5;
    localparam int LEGACY_DUTY_SHIFT  = 3;

endpackage
